//--- Bender.yml
package:
  name: micro_hash

sources:
  # design, in compile order
  - logic/micro_hash_pkg.sv
  - logic/round_ctrl_if.sv
  - logic/hash_control.sv
  - logic/round_counter.sv
  - logic/message_schedule.sv
  - logic/round_logic.sv
  - logic/micro_hash_top.sv

  # testbench
  - target: test
    files:
      - test/tb_clock.sv
      - test/micro_hash_tb.sv

//--- files.f
logic/micro_hash_pkg.sv
logic/round_ctrl_if.sv
logic/hash_control.sv
logic/round_counter.sv
logic/message_schedule.sv
logic/round_logic.sv
logic/micro_hash_top.sv
test/tb_clock.sv
test/micro_hash_tb.sv

//--- logic/hash_control.sv
// run sequencer, turns the ready level into load, step and finish strobes plus done
module hash_control (
    input  logic          clk,
    input  logic          reset,
    input  logic          ready,
    round_ctrl_if.control ctrl,
    output bit            done
);

    // LOAD is the cycle right after the block was captured, round 0 runs there
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        FINISH,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    // next state, ready low always drops back to idle
    always_comb begin
        state_next = state;
        if (!ready) begin
            state_next = IDLE;
        end else begin
            case (state)
                IDLE:    state_next = LOAD;
                LOAD:    state_next = RUN;
                // leave after the step of round 31
                RUN:     if (ctrl.last) state_next = FINISH;
                FINISH:  state_next = DONE;
                // hold while ready stays high
                DONE:    state_next = DONE;
                default: state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // strobes decoded from state, qualified by ready so an abort edge does nothing
    assign ctrl.load   = ready && (state == IDLE);
    assign ctrl.step   = ready && ((state == LOAD) || (state == RUN));
    assign ctrl.finish = ready && (state == FINISH);

    // done level, set with the finish edge
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!ready) begin
            done <= 1'b0;
        end else if (ctrl.finish) begin
            done <= 1'b1;
        end
    end

endmodule

//--- logic/message_schedule.sv
// message schedule window, supplies w(round) and expands words 16..31 on the fly
module message_schedule
    import micro_hash_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    round_ctrl_if.schedule ctrl,
    input  block_t         block,
    output byte_t          word
);

    // window[j] holds w(round + j)
    block_t window;
    byte_t  word_next;

    // next word enters at the top of the window
    // taps relative to the current round give w(i-3), w(i-9), w(i-14) of the new word
    assign word_next = (window[TAP_NEAR] | window[TAP_MID]) ^ window[TAP_FAR];

    always_ff @(posedge clk) begin
        if (reset) begin
            window <= '0;
        end else if (ctrl.load) begin
            // capture w0..w15 straight from the block
            window <= block;
        end else if (ctrl.step) begin
            // drop the used word, append the expanded one
            window <= {word_next, window[BLOCK_BYTES-1:1]};
        end
    end

    // current round word, valid during the step cycle
    assign word = window[0];

endmodule

//--- logic/micro_hash_pkg.sv
// shared types and constants for the micro hash core, imported by rtl and testbench
package micro_hash_pkg;

    // one hash byte, also one schedule word
    typedef logic [7:0] byte_t;

    localparam int BLOCK_BYTES = 16;
    localparam int ROUND_COUNT = 32;

    // first round that switches to OR and K_HIGH
    localparam int HALF_ROUNDS = 16;

    // input block, byte 0 is w0
    typedef byte_t [BLOCK_BYTES-1:0] block_t;

    // round index 0..31
    typedef logic [4:0] round_t;

    // a/b/c round state, reused as the final hash
    typedef struct packed {
        byte_t a;
        byte_t b;
        byte_t c;
    } hash_t;

    // initial state, also added back after the last round
    localparam hash_t H_INIT = '{a: 8'h01, b: 8'h89, c: 8'hFE};

    // round constants for the two halves
    localparam byte_t K_LOW  = 8'h99;
    localparam byte_t K_HIGH = 8'hA1;

    // window taps for the next schedule word
    // w(i+16) = (w(i+13) | w(i+7)) ^ w(i+2)
    localparam int TAP_NEAR = 13;
    localparam int TAP_MID  = 7;
    localparam int TAP_FAR  = 2;

endpackage

//--- logic/micro_hash_top.sv
// micro hash core top level, plain ports around the sequencer, counter, schedule and rounds
module micro_hash_top
    import micro_hash_pkg::*;
#(
    parameter int round_count = ROUND_COUNT
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   ready,
    // must stay stable from the load edge until done
    input  block_t block,
    output byte_t  hash_a,
    output byte_t  hash_b,
    output byte_t  hash_c,
    output bit     done
);

    // shared control bus
    round_ctrl_if ctrl_bus ();

    byte_t word;
    hash_t hash;

    // load / step / finish sequencing
    hash_control u_hash_control (
        .clk   (clk),
        .reset (reset),
        .ready (ready),
        .ctrl  (ctrl_bus.control),
        .done  (done)
    );

    round_counter #(
        .round_count (round_count)
    ) u_round_counter (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.counter)
    );

    // word for the current round
    message_schedule u_message_schedule (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.schedule),
        .block (block),
        .word  (word)
    );

    round_logic u_round_logic (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.rounds),
        .word  (word),
        .hash  (hash)
    );

    // result struct out to the byte ports
    assign hash_a = hash.a;
    assign hash_b = hash.b;
    assign hash_c = hash.c;

endmodule

//--- logic/round_counter.sv
// round index register for the hash rounds, flags the final round to the sequencer
module round_counter
    import micro_hash_pkg::*;
#(
    parameter int round_count = ROUND_COUNT
) (
    input  logic          clk,
    input  logic          reset,
    round_ctrl_if.counter ctrl
);

    // index of the final round
    localparam round_t LAST_ROUND = round_t'(round_count - 1);

    round_t round_q;

    // clears on load, one increment per step
    always_ff @(posedge clk) begin
        if (reset) begin
            round_q <= '0;
        end else if (ctrl.load) begin
            round_q <= '0;
        end else if (ctrl.step) begin
            // wraps to 0 after round 31, unused until the next load
            round_q <= round_q + round_t'(1);
        end
    end

    assign ctrl.round = round_q;

    // combinational so the sequencer sees it during the last step
    assign ctrl.last = (round_q == LAST_ROUND);

endmodule

//--- logic/round_ctrl_if.sv
// control bus from the sequencer and round counter to the schedule and round datapath
interface round_ctrl_if
    import micro_hash_pkg::*;
();

    // strobes from hash_control
    bit load;
    bit step;
    bit finish;

    // round position from round_counter
    round_t round;
    bit     last;

    // sequencer only needs to know when the rounds are over
    modport control (
        output load, step, finish,
        input  last
    );

    modport counter (
        input  load, step,
        output round, last
    );

    // window shifts on every step
    modport schedule (
        input load, step
    );

    modport rounds (
        input load, step, finish, round
    );

endinterface

//--- logic/round_logic.sv
// round datapath, updates a/b/c once per step and registers the final hash on finish
module round_logic
    import micro_hash_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    round_ctrl_if.rounds ctrl,
    input  byte_t        word,
    output hash_t        hash
);

    hash_t state;
    hash_t state_next;
    hash_t hash_sum;
    byte_t x;
    byte_t k;
    logic  high_half;

    // second half starts at round 16
    assign high_half = (ctrl.round >= round_t'(HALF_ROUNDS));

    // mixing term and round constant
    always_comb begin
        if (high_half) begin
            x = state.a | state.b;
            k = K_HIGH;
        end else begin
            x = state.a ^ state.b;
            k = K_LOW;
        end
    end

    // one round
    always_comb begin
        state_next.a = state.b ^ state.c;
        // c shifted left by 4, upper nibble falls off
        state_next.b = {state.c[3:0], 4'h0};
        // modulo 256 by the 8 bit target
        state_next.c = x + k + word;
    end

    // final bytes, each added to its initial value
    always_comb begin
        hash_sum.a = state.a + H_INIT.a;
        hash_sum.b = state.b + H_INIT.b;
        hash_sum.c = state.c + H_INIT.c;
    end

    // round state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
        end else if (ctrl.load) begin
            state <= H_INIT;
        end else if (ctrl.step) begin
            state <= state_next;
        end
    end

    // result register, only touched on finish
    // an aborted run leaves the previous result in place
    always_ff @(posedge clk) begin
        if (reset) begin
            hash <= '0;
        end else if (ctrl.finish) begin
            hash <= hash_sum;
        end
    end

endmodule

//--- test/micro_hash_tb.sv
// table-driven testbench for micro_hash_top, checks hash values, done timing, hold and abort
module micro_hash_tb
    import micro_hash_pkg::*;
();

    localparam int TABLE_LEN = 8;
    localparam int HOLD_CYCLES = 10;
    // edges with ready high up to done: load, 32 steps, finish
    localparam int RUN_EDGES = ROUND_COUNT + 2;
    localparam int FULL_HIGH = RUN_EDGES + HOLD_CYCLES;
    // load edge plus 10 rounds
    localparam int ABORT_HIGH = 11;
    localparam int DONE_WAIT_MAX = RUN_EDGES + 16;
    localparam int TIMEOUT_CYCLES = TABLE_LEN * 40 + 100;

    // one table row, full run when high_cycles reaches past done
    typedef struct {
        block_t blk;
        int     high_cycles;
    } entry_t;

    logic   clk;
    logic   reset;
    logic   ready;
    block_t block_in;
    byte_t  hash_a;
    byte_t  hash_b;
    byte_t  hash_c;
    bit     done;

    entry_t      stimulus [TABLE_LEN];
    hash_t       last_hash;
    logic [31:0] lcg_state;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;

    tb_clock #(
        .period (40)
    ) u_clock (
        .clk (clk)
    );

    micro_hash_top #(
        .round_count (ROUND_COUNT)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .ready  (ready),
        .block  (block_in),
        .hash_a (hash_a),
        .hash_b (hash_b),
        .hash_c (hash_c),
        .done   (done)
    );

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one byte per lcg step, taken from the middle bits
    function automatic block_t random_block();
        block_t blk;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            lcg_state = lcg_next(lcg_state);
            blk[i] = lcg_state[23:16];
        end
        return blk;
    endfunction

    // reference hash, straight from the round rule
    function automatic hash_t compute_hash(input block_t blk);
        byte_t w [ROUND_COUNT];
        hash_t s;
        hash_t result;
        byte_t x;
        byte_t k;
        byte_t na;
        byte_t nb;
        byte_t nc;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            w[i] = blk[i];
        end
        // expanded words 16..31
        for (int i = BLOCK_BYTES; i < ROUND_COUNT; i++) begin
            w[i] = (w[i-3] | w[i-9]) ^ w[i-14];
        end
        s = H_INIT;
        for (int i = 0; i < ROUND_COUNT; i++) begin
            if (i < HALF_ROUNDS) begin
                x = s.a ^ s.b;
                k = K_LOW;
            end else begin
                x = s.a | s.b;
                k = K_HIGH;
            end
            na = s.b ^ s.c;
            nb = byte_t'(s.c << 4);
            nc = x + k + w[i];
            s.a = na;
            s.b = nb;
            s.c = nc;
        end
        result.a = s.a + H_INIT.a;
        result.b = s.b + H_INIT.b;
        result.c = s.c + H_INIT.c;
        return result;
    endfunction

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input bit expected, input bit actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // all three output bytes against one expected result
    task automatic check_hash(input hash_t expected);
        check_byte("hash_a", expected.a, hash_a);
        check_byte("hash_b", expected.b, hash_b);
        check_byte("hash_c", expected.c, hash_c);
    endtask

    task automatic build_table();
        block_t incr;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            incr[i] = byte_t'(i);
        end
        stimulus[0] = '{blk: '0, high_cycles: FULL_HIGH};
        stimulus[1] = '{blk: '1, high_cycles: FULL_HIGH};
        stimulus[2] = '{blk: incr, high_cycles: FULL_HIGH};
        stimulus[3] = '{blk: random_block(), high_cycles: FULL_HIGH};
        stimulus[4] = '{blk: random_block(), high_cycles: FULL_HIGH};
        // dropped after 10 rounds, next row is a fresh full run
        stimulus[5] = '{blk: random_block(), high_cycles: ABORT_HIGH};
        stimulus[6] = '{blk: random_block(), high_cycles: FULL_HIGH};
        stimulus[7] = '{blk: random_block(), high_cycles: FULL_HIGH};
    endtask

    // full run, then hold, then drop ready
    task automatic run_full(input block_t blk, input int high_cycles);
        hash_t expected;
        int    edges;
        bit    seen;
        expected = compute_hash(blk);
        @(posedge clk);
        block_in <= blk;
        ready <= 1'b1;
        // load edge
        @(posedge clk);
        @(negedge clk);
        check_flag("done", 1'b0, done);
        check_hash(last_hash);
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < DONE_WAIT_MAX) begin
            @(posedge clk);
            @(negedge clk);
            edges++;
            if (done) begin
                seen = 1'b1;
            end else begin
                // old result stays until the finish edge
                check_hash(last_hash);
            end
        end
        if (!seen) begin
            other_errors++;
            $display("done never rose within %0d edges after the load edge, time %0t",
                     DONE_WAIT_MAX, $time);
        end else begin
            // finish edge comes 33 edges after the load edge
            check_count("done_edges", RUN_EDGES - 1, edges);
        end
        check_hash(expected);
        // ready held high, done and hash frozen
        for (int n = 1; n <= high_cycles - RUN_EDGES; n++) begin
            @(posedge clk);
            if (n == high_cycles - RUN_EDGES) begin
                ready <= 1'b0;
            end
            @(negedge clk);
            check_flag("done", 1'b1, done);
            check_hash(expected);
        end
        // edge that samples ready low
        @(posedge clk);
        @(negedge clk);
        check_flag("done", 1'b0, done);
        check_hash(expected);
        last_hash = expected;
    endtask

    // ready drops mid run, nothing may reach the outputs
    task automatic run_abort(input block_t blk, input int high_cycles);
        @(posedge clk);
        block_in <= blk;
        ready <= 1'b1;
        for (int h = 1; h <= high_cycles; h++) begin
            @(posedge clk);
            if (h == high_cycles) begin
                ready <= 1'b0;
            end
            @(negedge clk);
            check_flag("done", 1'b0, done);
            check_hash(last_hash);
        end
        // idle edges past the point where done would have risen
        for (int h = high_cycles + 1; h <= RUN_EDGES + 1; h++) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("done", 1'b0, done);
            check_hash(last_hash);
        end
    endtask

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        ready = 1'b0;
        block_in = '0;
        last_hash = '0;
        lcg_state = 32'h0137_4dd1;
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // outputs straight after reset
        @(negedge clk);
        check_flag("done", 1'b0, done);
        check_hash('0);
        for (int e = 0; e < TABLE_LEN; e++) begin
            if (stimulus[e].high_cycles > RUN_EDGES) begin
                run_full(stimulus[e].blk, stimulus[e].high_cycles);
            end else begin
                run_abort(stimulus[e].blk, stimulus[e].high_cycles);
            end
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
// free running clock for the micro hash testbench, instantiated by the testbench top
module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    // starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule
